// File: memtest_pkg.sv
package memtest_pkg;

    //////////////////////////////////////////////////
    // Board and clock constants
    //////////////////////////////////////////////////

    localparam int btn_count             = 7;         // Board buttons
    localparam int debounce_bits_default = 16;        // Hold-off counter width
    localparam int unsigned clk_gui_hz   = 50000000;  // Nominal GUI clock, Hz

    localparam int phase_bits    = 7;   // Phase counter, wraps mod 128
    localparam int btn_dn_index  = 5;   // Phase-down button
    localparam int btn_up_index  = 6;   // Phase-up button

    localparam int count_bits    = 32;  // Pass and fail counters from the tester
    localparam int secs_bits     = 16;  // Binary seconds
    localparam int prescale_bits = 32;  // Enough for 60 s at 50 MHz
    localparam int led_bits      = 8;

    //////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////

    // Debounced button word, bit i is button i
    typedef logic [btn_count-1:0] btn_word_t;

    // Dynamic phase shift control toward the SDRAM clock PLL
    typedef struct packed {
        logic step;  // Level, each rising edge is one phase step
        logic dir;   // 1 steps up, 0 steps down
    } phase_ctrl_t;

    // BCD digits, index 0 is the ones digit
    typedef logic [2:0][3:0] bcd3_t;  // Phase 000..127
    typedef logic [3:0][3:0] bcd4_t;  // Minutes 0000..9999

    // Everything the display needs in one word
    typedef struct packed {
        logic [count_bits-1:0] pass_count;
        logic [count_bits-1:0] fail_count;
        bcd3_t                 phase_bcd;
        bcd4_t                 mins_bcd;
        logic [secs_bits-1:0]  secs;      // Binary, not BCD
    } status_t;

endpackage

// File: button_debounce.sv
module button_debounce #(
    parameter int debounce_bits = memtest_pkg::debounce_bits_default
) (
    input  logic                              clk_gui,
    input  logic                              timer_reset,
    input  logic [memtest_pkg::btn_count-1:0] btn,
    output memtest_pkg::btn_word_t            btn_stable,
    output logic                              btn_new
);
    import memtest_pkg::*;

    //////////////////////////////////////////////////
    // Hold-off and sampling
    //////////////////////////////////////////////////

    logic [debounce_bits-1:0] holdoff_cnt;  // Counts up until top bit set
    btn_word_t                btn_prev;     // Previous sample
    logic                     sample_en;
    logic                     btn_changed;

    // Top bit set means hold-off over
    assign sample_en   = holdoff_cnt[debounce_bits-1];
    assign btn_changed = (btn_stable != btn_prev);

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            holdoff_cnt <= '0;
            btn_stable  <= '0;
            btn_prev    <= '0;
            btn_new     <= 1'b0;
        end else begin
            btn_new <= 1'b0;  // Pulse by default low
            if (sample_en) begin
                // Free running sampler while no change seen
                btn_stable <= btn;
                btn_prev   <= btn_stable;
                if (btn_changed) begin
                    holdoff_cnt <= '0;    // Restart hold-off
                    btn_new     <= 1'b1;  // One cycle, counter top bit drops next
                end
            end else begin
                // Sampler frozen, bounces ignored here
                holdoff_cnt <= holdoff_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Hold-off restart must block a second pulse right behind the first
    a_btn_new_single : assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        btn_new |=> !btn_new
    ) else $error("btn_new high on two consecutive cycles");

endmodule

// File: phase_stepper.sv
module phase_stepper (
    input  logic                   clk_gui,
    input  logic                   timer_reset,
    input  memtest_pkg::btn_word_t btn_stable,
    input  logic                   btn_new,
    output memtest_pkg::phase_ctrl_t phase_ctrl,
    output memtest_pkg::bcd3_t     phase_bcd
);
    import memtest_pkg::*;

    // Shift and add three, phase_bits of binary into three BCD digits
    function automatic bcd3_t bin_to_bcd3(input logic [phase_bits-1:0] bin);
        logic [phase_bits+$bits(bcd3_t)-1:0] sh;  // BCD digits above binary
        sh = '0;
        sh[phase_bits-1:0] = bin;
        for (int i = 0; i < phase_bits; i++) begin
            for (int d = 0; d < 3; d++) begin
                if (sh[phase_bits+4*d +: 4] > 4'd4) begin
                    sh[phase_bits+4*d +: 4] = sh[phase_bits+4*d +: 4] + 4'd3;
                end
            end
            sh = sh << 1;
        end
        return sh[phase_bits +: $bits(bcd3_t)];
    endfunction

    //////////////////////////////////////////////////
    // PLL step and direction
    //////////////////////////////////////////////////

    logic phase_btn;  // Either phase button down
    logic step_d;     // Step delayed for edge detect
    logic step_rise;

    logic [phase_bits-1:0] phase_cnt;

    assign phase_btn = btn_stable[btn_dn_index] | btn_stable[btn_up_index];
    assign step_rise = phase_ctrl.step & ~step_d;

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            phase_ctrl <= '0;
        end else if (btn_new) begin
            phase_ctrl.step <= phase_btn;  // Held press keeps step high
            if (phase_btn) begin
                phase_ctrl.dir <= btn_stable[btn_up_index];  // Up wins if both
            end
            // Release leaves dir alone
        end
    end

    //////////////////////////////////////////////////
    // Phase tracking for the display
    //////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            step_d    <= 1'b0;
            phase_cnt <= '0;
            phase_bcd <= '0;
        end else begin
            step_d <= phase_ctrl.step;
            if (step_rise) begin
                // One PLL step per press, wraps both ways
                if (phase_ctrl.dir) begin
                    phase_cnt <= phase_cnt + 1'b1;
                end else begin
                    phase_cnt <= phase_cnt - 1'b1;
                end
            end
            phase_bcd <= bin_to_bcd3(phase_cnt);  // One cycle behind counter
        end
    end

    // Conversion output must stay decimal for the display
    a_phase_bcd_digits : assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        (phase_bcd[0] <= 4'd9) && (phase_bcd[1] <= 4'd9) && (phase_bcd[2] <= 4'd1)
    ) else $error("phase_bcd digit out of range %h", phase_bcd);

endmodule

// File: elapsed_timer.sv
module elapsed_timer #(
    parameter int unsigned ticks_per_sec = memtest_pkg::clk_gui_hz
) (
    input  logic                              clk_gui,
    input  logic                              timer_reset,
    output memtest_pkg::bcd4_t                mins_bcd,
    output logic [memtest_pkg::secs_bits-1:0] secs
);
    import memtest_pkg::*;

    // BCD increment, ripple carry from ones digit, 9999 rolls to 0000
    function automatic bcd4_t bcd4_inc(input bcd4_t val);
        bcd4_t res;
        logic  carry;
        res   = val;
        carry = 1'b1;
        for (int d = 0; d < 4; d++) begin
            if (carry) begin
                if (res[d] == 4'd9) begin
                    res[d] = 4'd0;  // Carry on to next digit
                end else begin
                    res[d] = res[d] + 4'd1;
                    carry  = 1'b0;
                end
            end
        end
        return res;
    endfunction

    logic [prescale_bits-1:0] sec_presc;  // Ticks within current second
    logic [prescale_bits-1:0] min_presc;  // Ticks within current minute

    //////////////////////////////////////////////////
    // Seconds, binary
    //////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            sec_presc <= '0;
            secs      <= '0;
        end else if (sec_presc == prescale_bits'(ticks_per_sec - 1)) begin
            sec_presc <= '0;
            secs      <= secs + 1'b1;  // Wraps after 65535 s
        end else begin
            sec_presc <= sec_presc + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Minutes, BCD
    //////////////////////////////////////////////////

    // Own prescaler so minutes stay exact after secs wraps
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            min_presc <= '0;
            mins_bcd  <= '0;
        end else if (min_presc == prescale_bits'(ticks_per_sec * 60 - 1)) begin
            min_presc <= '0;
            mins_bcd  <= bcd4_inc(mins_bcd);
        end else begin
            min_presc <= min_presc + 1'b1;
        end
    end

    // Every digit decimal across all carries
    a_mins_bcd_digits : assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        (mins_bcd[0] <= 4'd9) && (mins_bcd[1] <= 4'd9) &&
        (mins_bcd[2] <= 4'd9) && (mins_bcd[3] <= 4'd9)
    ) else $error("mins_bcd digit out of range %h", mins_bcd);

endmodule

// File: memtest_gui_top.sv
module memtest_gui_top #(
    parameter int          debounce_bits = memtest_pkg::debounce_bits_default,
    parameter int unsigned ticks_per_sec = memtest_pkg::clk_gui_hz
) (
    input  logic                               clk_gui,
    input  logic                               timer_reset,
    input  logic [memtest_pkg::btn_count-1:0]  btn,         // Raw board buttons
    input  logic [memtest_pkg::count_bits-1:0] pass_count,
    input  logic [memtest_pkg::count_bits-1:0] fail_count,
    output memtest_pkg::phase_ctrl_t           phase_ctrl,  // To SDRAM clock PLL
    output memtest_pkg::status_t               status,      // To display
    output logic [memtest_pkg::led_bits-1:0]   led
);
    import memtest_pkg::*;

    btn_word_t             btn_stable;
    logic                  btn_new;
    bcd3_t                 phase_bcd;
    bcd4_t                 mins_bcd;
    logic [secs_bits-1:0]  secs;

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    button_debounce #(
        .debounce_bits (debounce_bits)
    ) u_button_debounce (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn         (btn),
        .btn_stable  (btn_stable),
        .btn_new     (btn_new)
    );

    phase_stepper u_phase_stepper (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn_stable  (btn_stable),
        .btn_new     (btn_new),
        .phase_ctrl  (phase_ctrl),
        .phase_bcd   (phase_bcd)
    );

    elapsed_timer #(
        .ticks_per_sec (ticks_per_sec)
    ) u_elapsed_timer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .mins_bcd    (mins_bcd),
        .secs        (secs)
    );

    // Display bundle
    assign status = '{pass_count: pass_count, fail_count: fail_count,
                      phase_bcd: phase_bcd, mins_bcd: mins_bcd, secs: secs};

    assign led = fail_count[led_bits-1:0];  // Low fail bits, most telling

endmodule

// File: memtest_gui_tb.sv
module memtest_gui_tb;
    import memtest_pkg::*;

    localparam int tb_debounce_bits = 4;   // Hold-off of 8 cycles
    localparam int tb_ticks         = 4;   // Four cycles per "second"
    localparam int clk_period       = 10;

    // One vector line as read from the file
    typedef struct packed {
        btn_word_t             btn;
        logic [15:0]           hold;   // Cycles to hold btn
        logic [phase_bits-1:0] phase;  // Expected phase at end of hold
        phase_ctrl_t           ctrl;   // Expected step and dir
    } vector_t;

    logic                  clk_gui;
    logic                  timer_reset;
    logic [btn_count-1:0]  btn;
    logic [count_bits-1:0] pass_count;
    logic [count_bits-1:0] fail_count;
    phase_ctrl_t           phase_ctrl;
    status_t               status;
    logic [led_bits-1:0]   led;

    vector_t     vectors[$];
    int          total_hold;          // Sum of all hold cycles, sizes the watchdog
    int          cycle_cnt;           // Rising edges since reset release
    int          mismatch_count;
    int          other_count;
    bit          load_done;
    logic [31:0] rng;

    memtest_gui_top #(
        .debounce_bits (tb_debounce_bits),
        .ticks_per_sec (tb_ticks)
    ) UUT (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .btn         (btn),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .phase_ctrl  (phase_ctrl),
        .status      (status),
        .led         (led)
    );

    initial begin
        clk_gui = 1'b0;
        forever #(clk_period / 2) clk_gui = ~clk_gui;
    end

    always @(posedge clk_gui) begin
        if (timer_reset) cycle_cnt <= 0;
        else cycle_cnt <= cycle_cnt + 1;  // Same edges the timer counts
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Decimal digits by division, ones digit at index 0
    function automatic bcd3_t to_bcd3(input int val);
        bcd3_t r;
        r[2] = 4'(val / 100);
        r[1] = 4'((val / 10) % 10);
        r[0] = 4'(val % 10);
        return r;
    endfunction

    function automatic bcd4_t to_bcd4(input int val);
        bcd4_t r;
        r[3] = 4'((val / 1000) % 10);
        r[2] = 4'((val / 100) % 10);
        r[1] = 4'((val / 10) % 10);
        r[0] = 4'(val % 10);
        return r;
    endfunction

    task automatic check_phase_ctrl(input phase_ctrl_t exp, input phase_ctrl_t act);
        if (exp !== act) begin
            $display("FAILED time=%0t phase_ctrl expected step=%b dir=%b actual step=%b dir=%b",
                     $time, exp.step, exp.dir, act.step, act.dir);
            mismatch_count++;
        end
    endtask

    task automatic check_bcd3(input string name, input bcd3_t exp, input bcd3_t act);
        if (exp !== act) begin
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_bcd4(input string name, input bcd4_t exp, input bcd4_t act);
        if (exp !== act) begin
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_secs(input logic [secs_bits-1:0] exp, input logic [secs_bits-1:0] act);
        if (exp !== act) begin
            $display("FAILED time=%0t status.secs expected=%0d actual=%0d", $time, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_leds(input logic [led_bits-1:0] exp, input logic [led_bits-1:0] act);
        if (exp !== act) begin
            $display("FAILED time=%0t led expected=%h actual=%h", $time, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input logic [count_bits-1:0] exp,
                               input logic [count_bits-1:0] act);
        if (exp !== act) begin
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    // All outputs against the model at one vector boundary
    task automatic check_outputs(input phase_ctrl_t exp_ctrl, input int exp_phase);
        check_phase_ctrl(exp_ctrl, phase_ctrl);
        check_bcd3("status.phase_bcd", to_bcd3(exp_phase), status.phase_bcd);
        check_secs(secs_bits'(cycle_cnt / tb_ticks), status.secs);
        check_bcd4("status.mins_bcd", to_bcd4((cycle_cnt / (60 * tb_ticks)) % 10000),
                   status.mins_bcd);
        check_leds(fail_count[led_bits-1:0], led);  // LEDs mirror low fail bits
        check_count("status.pass_count", pass_count, status.pass_count);
        check_count("status.fail_count", fail_count, status.fail_count);
    endtask

    task automatic load_vectors();
        int      fd;
        int      code;
        int      nf;
        int      line_no;
        int      f_btn;
        int      f_hold;
        int      f_phase;
        int      f_dir;
        int      f_step;
        string   line;
        vector_t v;
        fd = $fopen("memtest_gui_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file memtest_gui_vectors.txt");
            other_count++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            line_no++;
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
            nf = $sscanf(line, "%h %d %d %d %d", f_btn, f_hold, f_phase, f_dir, f_step);
            if (nf != 5 || f_btn < 0 || f_btn >= (1 << btn_count) || f_hold < 1 ||
                f_phase < 0 || f_phase >= (1 << phase_bits) || f_dir > 1 || f_step > 1) begin
                $display("Vector file line %0d is malformed and was skipped", line_no);
                other_count++;
            end else begin
                v.btn      = btn_word_t'(f_btn);
                v.hold     = 16'(f_hold);
                v.phase    = phase_bits'(f_phase);
                v.ctrl.dir  = f_dir[0];
                v.ctrl.step = f_step[0];
                vectors.push_back(v);
                total_hold += f_hold;
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The vector file holds no usable vectors");
            other_count++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Stimulus and watchdog
    //////////////////////////////////////////////////

    initial begin
        timer_reset = 1'b1;
        btn         = '0;
        pass_count  = '0;
        fail_count  = '0;
        rng         = 32'hfdcf1b59;
        load_vectors();
        load_done = 1'b1;
        repeat (4) @(posedge clk_gui);
        #1;
        timer_reset = 1'b0;
        check_outputs('0, 0);  // Reset state
        foreach (vectors[i]) begin
            btn        = vectors[i].btn;
            pass_count = rng;
            rng        = xorshift32(rng);
            fail_count = rng;
            rng        = xorshift32(rng);
            repeat (vectors[i].hold) @(posedge clk_gui);
            #1;  // Outputs settled, next drive follows the checks
            check_outputs(vectors[i].ctrl, int'(vectors[i].phase));
        end
        finish_run();
    end

    initial begin
        wait (load_done);
        #((total_hold + 20) * clk_period);
        $display("Timeout after %0d cycles, the vector run did not complete", total_hold + 20);
        other_count++;
        finish_run();
    end

endmodule

// File: memtest_gui_vectors.txt
# btn(hex) hold(cycles) phase(dec) dir step
# Expected phase, dir and step hold at the end of each line's hold
00 24 0 0 0
40 24 1 1 1
00 24 1 1 0
40 24 2 1 1
00 24 2 1 0
41 24 3 1 1
00 24 3 1 0
20 24 2 0 1
00 24 2 0 0
20 24 1 0 1
00 24 1 0 0
20 24 0 0 1
00 24 0 0 0
20 24 127 0 1
00 24 127 0 0
60 24 0 1 1
00 3 0 1 0
40 2 0 1 0
00 24 0 1 0
01 24 0 1 0
20 24 127 0 1
08 24 127 0 0
00 1200 127 0 0
00 1400 127 0 0

// File: compile.f
memtest_pkg.sv
button_debounce.sv
phase_stepper.sv
elapsed_timer.sv
memtest_gui_top.sv
memtest_gui_tb.sv

// File: run_sim.sh
#!/bin/bash
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module memtest_gui_tb \
    -o memtest_gui_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/memtest_gui_sim 2>&1 | tee sim.log || { echo "Simulation aborted"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && { echo "Test failed"; exit 1; } || exit 0
